/* cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and register file sizes
`define CPU_DATA_W        32
`define CPU_REG_SEL_W     4
`define CPU_NUM_REGS      16
`define CPU_IMM_W         16
`define CPU_OPCODE_W      4
`define CPU_GROUP_W       4
// shifts only look at the low bits of operand b
`define CPU_SHAMT_W       5

// program counter stepping and stall behaviour
`define CPU_INSTR_BYTES   4
`define CPU_STALL_CYCLES  3
`define CPU_STALL_CNT_W   2
`define CPU_RESET_PC      0

// group field, common to every instruction
`define CPU_F_GRP_LO      28
// three-register layout (groups 0, 2, 3)
`define CPU_F3_RA_LO      24
`define CPU_F3_RB_LO      20
`define CPU_F3_RC_LO      16
`define CPU_F3_OP_LO      0
// register-immediate layout (group 1)
`define CPU_F1_OP_LO      24
`define CPU_F1_RA_LO      20
`define CPU_F1_RB_LO      16
`define CPU_F1_IMM_LO     0

`endif

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

	// alu operation select
	typedef enum logic [`CPU_OPCODE_W-1:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sltu = 4'd2,
		alu_slts = 4'd3,
		alu_and  = 4'd4,
		alu_orr  = 4'd5,
		alu_xor  = 4'd6,
		alu_lsl  = 4'd7,
		alu_lsr  = 4'd8,
		alu_asr  = 4'd9
	} alu_op_e;

	// group 0 maps straight onto the alu, 10 and up are bad
	typedef enum logic [`CPU_OPCODE_W-1:0] {
		g0_add  = 4'd0,
		g0_sub  = 4'd1,
		g0_sltu = 4'd2,
		g0_slts = 4'd3,
		g0_and  = 4'd4,
		g0_orr  = 4'd5,
		g0_xor  = 4'd6,
		g0_lsl  = 4'd7,
		g0_lsr  = 4'd8,
		g0_asr  = 4'd9
	} grp0_op_e;

	// group 1, register and immediate
	typedef enum logic [`CPU_OPCODE_W-1:0] {
		g1_addi  = 4'd0,
		g1_subi  = 4'd1,
		g1_sltui = 4'd2,
		g1_sltsi = 4'd3,
		g1_andi  = 4'd4,
		g1_orri  = 4'd5,
		g1_xori  = 4'd6,
		g1_lsli  = 4'd7,
		g1_lsri  = 4'd8,
		g1_asri  = 4'd9,
		g1_addsi = 4'd10,
		g1_cpyhi = 4'd11,
		g1_bne   = 4'd12,
		g1_beq   = 4'd13
	} grp1_op_e;

	// group 2, jumps through rC
	typedef enum logic [`CPU_OPCODE_W-1:0] {
		g2_jne = 4'd0,
		g2_jeq = 4'd1
	} grp2_op_e;

	// group 3, memory
	typedef enum logic [`CPU_OPCODE_W-1:0] {
		g3_st32 = 4'd0
	} grp3_op_e;

	typedef enum logic [`CPU_GROUP_W-1:0] {
		grp_alu  = 4'd0,
		grp_imm  = 4'd1,
		grp_jump = 4'd2,
		grp_mem  = 4'd3
	} instr_group_e;

	typedef enum logic {
		st_init,
		st_mem_access
	} stall_state_e;

endpackage

`default_nettype wire

/* instr_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module instr_decoder
(
	input  logic [`CPU_DATA_W-1:0]    instr,
	output cpu_pkg::instr_group_e     group,
	output logic [`CPU_OPCODE_W-1:0]  opcode,
	output logic [`CPU_REG_SEL_W-1:0] ra_idx,
	output logic [`CPU_REG_SEL_W-1:0] rb_idx,
	output logic [`CPU_REG_SEL_W-1:0] rc_idx,
	output logic [`CPU_IMM_W-1:0]     imm,
	output logic                      causes_stall
);
	import cpu_pkg::*;

	always_comb
	begin
		group = instr_group_e'(instr[`CPU_F_GRP_LO +: `CPU_GROUP_W]);

		if (group == grp_imm)
		begin
			// opcode sits high, registers shift down by one field
			opcode = instr[`CPU_F1_OP_LO +: `CPU_OPCODE_W];
			ra_idx = instr[`CPU_F1_RA_LO +: `CPU_REG_SEL_W];
			rb_idx = instr[`CPU_F1_RB_LO +: `CPU_REG_SEL_W];
			rc_idx = '0;
			imm    = instr[`CPU_F1_IMM_LO +: `CPU_IMM_W];
		end
		else
		begin
			// three registers, opcode in the low nibble
			opcode = instr[`CPU_F3_OP_LO +: `CPU_OPCODE_W];
			ra_idx = instr[`CPU_F3_RA_LO +: `CPU_REG_SEL_W];
			rb_idx = instr[`CPU_F3_RB_LO +: `CPU_REG_SEL_W];
			rc_idx = instr[`CPU_F3_RC_LO +: `CPU_REG_SEL_W];
			imm    = '0;
		end

		// control flow and memory wait for the later stages
		case (group)
			grp_imm:  causes_stall = (opcode == g1_bne) || (opcode == g1_beq);
			grp_jump: causes_stall = 1'b1;
			grp_mem:  causes_stall = 1'b1;
			default:  causes_stall = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* register_file.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module register_file
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`CPU_REG_SEL_W-1:0] rd_sel_a,
	input  logic [`CPU_REG_SEL_W-1:0] rd_sel_b,
	input  logic [`CPU_REG_SEL_W-1:0] rd_sel_c,
	input  logic                      wr_en,
	input  logic [`CPU_REG_SEL_W-1:0] wr_sel,
	input  logic [`CPU_DATA_W-1:0]    wr_data,
	output logic [`CPU_DATA_W-1:0]    rd_data_a,
	output logic [`CPU_DATA_W-1:0]    rd_data_b,
	output logic [`CPU_DATA_W-1:0]    rd_data_c
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

	// single write port, r0 is never stored
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en && (wr_sel != '0))
		begin
			regs[wr_sel] <= wr_data;
		end
	end

	// combinational reads, r0 forced to zero
	assign rd_data_a = (rd_sel_a == '0) ? '0 : regs[rd_sel_a];
	assign rd_data_b = (rd_sel_b == '0) ? '0 : regs[rd_sel_b];
	assign rd_data_c = (rd_sel_c == '0) ? '0 : regs[rd_sel_c];

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module alu
(
	input  logic [`CPU_DATA_W-1:0] a,
	input  logic [`CPU_DATA_W-1:0] b,
	input  cpu_pkg::alu_op_e       op,
	output logic [`CPU_DATA_W-1:0] result
);
	import cpu_pkg::*;

	logic [`CPU_SHAMT_W-1:0] shamt;

	// shift distance from the low bits of b only
	assign shamt = b[`CPU_SHAMT_W-1:0];

	always_comb
	begin
		case (op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			// compares give 0 or 1 in bit 0
			alu_sltu: result = `CPU_DATA_W'(a < b);
			alu_slts: result = `CPU_DATA_W'($signed(a) < $signed(b));
			alu_and:  result = a & b;
			alu_orr:  result = a | b;
			alu_xor:  result = a ^ b;
			alu_lsl:  result = a << shamt;
			alu_lsr:  result = a >> shamt;
			// arithmetic shift keeps the sign bit
			alu_asr:  result = $signed(a) >>> shamt;
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module decode_stage
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  cpu_pkg::instr_group_e     group,
	input  logic [`CPU_OPCODE_W-1:0]  opcode,
	input  logic [`CPU_REG_SEL_W-1:0] ra_idx,
	input  logic [`CPU_REG_SEL_W-1:0] rb_idx,
	input  logic [`CPU_REG_SEL_W-1:0] rc_idx,
	input  logic [`CPU_IMM_W-1:0]     imm,
	input  logic                      causes_stall,
	input  logic [`CPU_DATA_W-1:0]    next_pc,
	input  logic [`CPU_DATA_W-1:0]    alu_result,
	input  logic [`CPU_DATA_W-1:0]    rd_data_a,
	output logic [`CPU_DATA_W-1:0]    mem_addr,
	output logic [`CPU_DATA_W-1:0]    mem_wdata,
	output logic                      mem_write,
	output logic [`CPU_REG_SEL_W-1:0] rd_sel_a,
	output logic [`CPU_REG_SEL_W-1:0] rd_sel_b,
	output logic [`CPU_REG_SEL_W-1:0] rd_sel_c,
	output logic                      ex_valid,
	output cpu_pkg::instr_group_e     ex_group,
	output logic [`CPU_OPCODE_W-1:0]  ex_opcode,
	output logic [`CPU_REG_SEL_W-1:0] ex_ra_idx,
	output logic [`CPU_IMM_W-1:0]     ex_imm,
	output logic [`CPU_DATA_W-1:0]    ex_pc
);
	import cpu_pkg::*;

	logic [`CPU_DATA_W-1:0]      pc;
	logic [`CPU_DATA_W-1:0]      seq_pc;
	logic [`CPU_STALL_CNT_W-1:0] stall_cnt;
	stall_state_e                stall_state;
	logic                        stalled;
	logic                        store_issue;

	assign seq_pc  = pc + `CPU_DATA_W'(`CPU_INSTR_BYTES);
	assign stalled = (stall_cnt != '0);
	// first stall cycle of a store, execute has rB + rC on the alu now
	assign store_issue = stalled && (stall_state == st_mem_access) &&
		(stall_cnt == `CPU_STALL_CNT_W'(`CPU_STALL_CYCLES));

	// pc, stall counter and the fetch or store address
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			// count of 1 makes the first cycle load pc from next_pc
			pc          <= `CPU_DATA_W'(`CPU_RESET_PC);
			mem_addr    <= `CPU_DATA_W'(`CPU_RESET_PC);
			mem_write   <= 1'b0;
			stall_cnt   <= `CPU_STALL_CNT_W'(1);
			stall_state <= st_init;
			ex_valid    <= 1'b0;
		end
		else if (stalled)
		begin
			stall_cnt <= stall_cnt - 1'b1;
			// bubbles while stalled
			ex_valid  <= 1'b0;
			mem_write <= store_issue;
			if (stall_cnt == `CPU_STALL_CNT_W'(1))
			begin
				// last stall cycle, resume at the resolved target
				pc       <= next_pc;
				mem_addr <= next_pc;
			end
			else if (store_issue)
			begin
				mem_addr <= alu_result;
			end
		end
		else
		begin
			ex_valid  <= 1'b1;
			mem_write <= 1'b0;
			if (causes_stall)
			begin
				stall_cnt <= `CPU_STALL_CNT_W'(`CPU_STALL_CYCLES);
				// only st32 touches memory, other group 3 codes just wait
				if ((group == grp_mem) && (opcode == g3_st32))
					stall_state <= st_mem_access;
				else
					stall_state <= st_init;
			end
			else
			begin
				pc       <= seq_pc;
				mem_addr <= seq_pc;
			end
		end
	end

	// decode to execute register and register read selects
	always_ff @(posedge clk)
	begin
		if (!stalled)
		begin
			rd_sel_a  <= ra_idx;
			rd_sel_b  <= rb_idx;
			rd_sel_c  <= rc_idx;
			ex_group  <= group;
			ex_opcode <= opcode;
			ex_ra_idx <= ra_idx;
			ex_imm    <= imm;
			ex_pc     <= pc;
		end
		// store data is rA, read during execute
		if (store_issue)
			mem_wdata <= rd_data_a;
	end

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module execute_stage
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ex_valid,
	input  cpu_pkg::instr_group_e     ex_group,
	input  logic [`CPU_OPCODE_W-1:0]  ex_opcode,
	input  logic [`CPU_REG_SEL_W-1:0] ex_ra_idx,
	input  logic [`CPU_IMM_W-1:0]     ex_imm,
	input  logic [`CPU_DATA_W-1:0]    ex_pc,
	input  logic [`CPU_DATA_W-1:0]    rd_data_a,
	input  logic [`CPU_DATA_W-1:0]    rd_data_b,
	input  logic [`CPU_DATA_W-1:0]    rd_data_c,
	input  logic [`CPU_DATA_W-1:0]    alu_result,
	output logic [`CPU_DATA_W-1:0]    alu_a,
	output logic [`CPU_DATA_W-1:0]    alu_b,
	output cpu_pkg::alu_op_e          alu_op,
	output logic [`CPU_DATA_W-1:0]    next_pc,
	output logic                      wb_valid,
	output cpu_pkg::instr_group_e     wb_group,
	output logic [`CPU_OPCODE_W-1:0]  wb_opcode,
	output logic [`CPU_REG_SEL_W-1:0] wb_ra_idx,
	output logic [`CPU_DATA_W-1:0]    wb_result
);
	import cpu_pkg::*;

	logic [`CPU_DATA_W-1:0] pc_plus4;
	logic [`CPU_DATA_W-1:0] simm;
	logic [`CPU_DATA_W-1:0] zimm;
	logic [`CPU_DATA_W-1:0] target;
	logic                   taken;

	assign pc_plus4 = ex_pc + `CPU_DATA_W'(`CPU_INSTR_BYTES);
	assign simm = {{(`CPU_DATA_W - `CPU_IMM_W){ex_imm[`CPU_IMM_W-1]}}, ex_imm};
	assign zimm = {{(`CPU_DATA_W - `CPU_IMM_W){1'b0}}, ex_imm};

	// operand selection, unused cases leave the alu adding zeros
	always_comb
	begin
		alu_a  = '0;
		alu_b  = '0;
		alu_op = alu_add;
		case (ex_group)
			grp_alu:
			begin
				alu_a  = rd_data_b;
				alu_b  = rd_data_c;
				alu_op = alu_op_e'(ex_opcode);
			end
			grp_imm:
			begin
				case (ex_opcode)
					g1_addi, g1_subi, g1_sltui, g1_andi, g1_orri,
					g1_xori, g1_lsli, g1_lsri, g1_asri:
					begin
						alu_a  = rd_data_b;
						alu_b  = zimm;
						alu_op = alu_op_e'(ex_opcode);
					end
					g1_sltsi:
					begin
						alu_a  = rd_data_b;
						alu_b  = simm;
						alu_op = alu_slts;
					end
					// pc relative value
					g1_addsi:
					begin
						alu_a = ex_pc;
						alu_b = simm;
					end
					// branch target, relative to the following instruction
					g1_bne, g1_beq:
					begin
						alu_a = pc_plus4;
						alu_b = simm;
					end
					default:
					begin
					end
				endcase
			end
			// store address rB + rC
			grp_mem:
			begin
				alu_a = rd_data_b;
				alu_b = rd_data_c;
			end
			default:
			begin
			end
		endcase
	end

	// branch and jump resolution, rA against rB
	always_comb
	begin
		taken  = 1'b0;
		target = alu_result;
		if (ex_group == grp_imm)
		begin
			if (ex_opcode == g1_bne)
				taken = (rd_data_a != rd_data_b);
			else if (ex_opcode == g1_beq)
				taken = (rd_data_a == rd_data_b);
		end
		else if (ex_group == grp_jump)
		begin
			target = rd_data_c;
			if (ex_opcode == g2_jne)
				taken = (rd_data_a != rd_data_b);
			else if (ex_opcode == g2_jeq)
				taken = (rd_data_a == rd_data_b);
		end
	end

	// held through the bubbles until decode picks it up
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			next_pc <= `CPU_DATA_W'(`CPU_RESET_PC);
		else if (ex_valid)
			next_pc <= taken ? target : pc_plus4;
	end

	// cpyhi keeps the low half of rA
	assign wb_result = ((ex_group == grp_imm) && (ex_opcode == g1_cpyhi)) ?
		{ex_imm, rd_data_a[`CPU_IMM_W-1:0]} : alu_result;

	assign wb_valid  = ex_valid;
	assign wb_group  = ex_group;
	assign wb_opcode = ex_opcode;
	assign wb_ra_idx = ex_ra_idx;

endmodule

`default_nettype wire

/* write_back_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module write_back_stage
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      wb_valid,
	input  cpu_pkg::instr_group_e     wb_group,
	input  logic [`CPU_OPCODE_W-1:0]  wb_opcode,
	input  logic [`CPU_REG_SEL_W-1:0] wb_ra_idx,
	input  logic [`CPU_DATA_W-1:0]    wb_result,
	output logic                      reg_wr_en,
	output logic [`CPU_REG_SEL_W-1:0] reg_wr_sel,
	output logic [`CPU_DATA_W-1:0]    reg_wr_data
);
	import cpu_pkg::*;

	logic writes_ra;

	// only alu and immediate results land in rA
	always_comb
	begin
		case (wb_group)
			grp_alu: writes_ra = (wb_opcode <= g0_asr);
			grp_imm: writes_ra = (wb_opcode <= g1_cpyhi);
			default: writes_ra = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			reg_wr_en <= 1'b0;
		else
			reg_wr_en <= wb_valid && writes_ra;
	end

	// write port payload
	always_ff @(posedge clk)
	begin
		if (wb_valid)
		begin
			reg_wr_sel  <= wb_ra_idx;
			reg_wr_data <= wb_result;
		end
	end

endmodule

`default_nettype wire

/* cpu_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_top
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_DATA_W-1:0] instr,
	output logic [`CPU_DATA_W-1:0] mem_addr,
	output logic [`CPU_DATA_W-1:0] mem_wdata,
	output logic                   mem_write
);
	import cpu_pkg::*;

	// decoder outputs
	instr_group_e              group;
	logic [`CPU_OPCODE_W-1:0]  opcode;
	logic [`CPU_REG_SEL_W-1:0] ra_idx;
	logic [`CPU_REG_SEL_W-1:0] rb_idx;
	logic [`CPU_REG_SEL_W-1:0] rc_idx;
	logic [`CPU_IMM_W-1:0]     imm;
	logic                      causes_stall;

	// register file ports
	logic [`CPU_REG_SEL_W-1:0] rd_sel_a;
	logic [`CPU_REG_SEL_W-1:0] rd_sel_b;
	logic [`CPU_REG_SEL_W-1:0] rd_sel_c;
	logic [`CPU_DATA_W-1:0]    rd_data_a;
	logic [`CPU_DATA_W-1:0]    rd_data_b;
	logic [`CPU_DATA_W-1:0]    rd_data_c;
	logic                      reg_wr_en;
	logic [`CPU_REG_SEL_W-1:0] reg_wr_sel;
	logic [`CPU_DATA_W-1:0]    reg_wr_data;

	// alu
	logic [`CPU_DATA_W-1:0]    alu_a;
	logic [`CPU_DATA_W-1:0]    alu_b;
	alu_op_e                   alu_op;
	logic [`CPU_DATA_W-1:0]    alu_result;

	// decode to execute
	logic                      ex_valid;
	instr_group_e              ex_group;
	logic [`CPU_OPCODE_W-1:0]  ex_opcode;
	logic [`CPU_REG_SEL_W-1:0] ex_ra_idx;
	logic [`CPU_IMM_W-1:0]     ex_imm;
	logic [`CPU_DATA_W-1:0]    ex_pc;
	logic [`CPU_DATA_W-1:0]    next_pc;

	// execute to write back
	logic                      wb_valid;
	instr_group_e              wb_group;
	logic [`CPU_OPCODE_W-1:0]  wb_opcode;
	logic [`CPU_REG_SEL_W-1:0] wb_ra_idx;
	logic [`CPU_DATA_W-1:0]    wb_result;

	instr_decoder u_decoder (.instr(instr), .group(group), .opcode(opcode),
		.ra_idx(ra_idx), .rb_idx(rb_idx), .rc_idx(rc_idx), .imm(imm),
		.causes_stall(causes_stall));

	register_file u_regs (.clk(clk), .rst_n(rst_n), .rd_sel_a(rd_sel_a),
		.rd_sel_b(rd_sel_b), .rd_sel_c(rd_sel_c), .wr_en(reg_wr_en),
		.wr_sel(reg_wr_sel), .wr_data(reg_wr_data), .rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b), .rd_data_c(rd_data_c));

	alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result));

	decode_stage u_decode (.clk(clk), .rst_n(rst_n), .group(group),
		.opcode(opcode), .ra_idx(ra_idx), .rb_idx(rb_idx), .rc_idx(rc_idx),
		.imm(imm), .causes_stall(causes_stall), .next_pc(next_pc),
		.alu_result(alu_result), .rd_data_a(rd_data_a), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_write(mem_write), .rd_sel_a(rd_sel_a),
		.rd_sel_b(rd_sel_b), .rd_sel_c(rd_sel_c), .ex_valid(ex_valid),
		.ex_group(ex_group), .ex_opcode(ex_opcode), .ex_ra_idx(ex_ra_idx),
		.ex_imm(ex_imm), .ex_pc(ex_pc));

	execute_stage u_execute (.clk(clk), .rst_n(rst_n), .ex_valid(ex_valid),
		.ex_group(ex_group), .ex_opcode(ex_opcode), .ex_ra_idx(ex_ra_idx),
		.ex_imm(ex_imm), .ex_pc(ex_pc), .rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b), .rd_data_c(rd_data_c), .alu_result(alu_result),
		.alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .next_pc(next_pc),
		.wb_valid(wb_valid), .wb_group(wb_group), .wb_opcode(wb_opcode),
		.wb_ra_idx(wb_ra_idx), .wb_result(wb_result));

	write_back_stage u_write_back (.clk(clk), .rst_n(rst_n),
		.wb_valid(wb_valid), .wb_group(wb_group), .wb_opcode(wb_opcode),
		.wb_ra_idx(wb_ra_idx), .wb_result(wb_result), .reg_wr_en(reg_wr_en),
		.reg_wr_sel(reg_wr_sel), .reg_wr_data(reg_wr_data));

endmodule

`default_nettype wire

/* tb_cpu_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module tb_cpu_top;
	import cpu_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int MEM_WORDS   = 256;
	localparam int NUM_TESTS   = 6;
	// longest program runs about 100 cycles
	localparam int TEST_BUDGET = 300;
	localparam int IDLE_LIMIT  = 30;
	localparam int WATCHDOG_NS = NUM_TESTS * (TEST_BUDGET + 20) * CLK_PERIOD;
	// group 4 is never decoded so it runs as a no-op
	localparam logic [`CPU_DATA_W-1:0] NOP_WORD = 32'h4000_0000;

	logic                   clk;
	logic                   rst_n;
	logic [`CPU_DATA_W-1:0] instr;
	logic [`CPU_DATA_W-1:0] mem_addr;
	logic [`CPU_DATA_W-1:0] mem_wdata;
	logic                   mem_write;

	// program image and the program write pointer in words
	logic [`CPU_DATA_W-1:0] prog_mem [MEM_WORDS];
	int                     wp;

	// observed and expected stores in order
	logic [`CPU_DATA_W-1:0] wr_addr_q [$];
	logic [`CPU_DATA_W-1:0] wr_data_q [$];
	logic [`CPU_DATA_W-1:0] exp_addr_q [$];
	logic [`CPU_DATA_W-1:0] exp_data_q [$];

	logic [`CPU_DATA_W-1:0] lfsr_state;
	int                     err_count;
	int                     num_checks;

	cpu_top DUT
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.instr     (instr),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_write (mem_write)
	);

	// combinational fetch with the low address bits picking the word
	assign instr = prog_mem[mem_addr[9:2]];

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// store log sampled mid-cycle while mem_write is steady
	always @(negedge clk)
	begin
		if (rst_n && mem_write)
		begin
			wr_addr_q.push_back(mem_addr);
			wr_data_q.push_back(mem_wdata);
		end
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [`CPU_DATA_W-1:0] random_bits(input int nbits);
		logic [`CPU_DATA_W-1:0] value;
		value = '0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'he000_0200 : 32'h0);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// expected alu results from the instruction set rules
	function automatic logic [`CPU_DATA_W-1:0] reference_alu(input alu_op_e op,
		input logic [`CPU_DATA_W-1:0] a, input logic [`CPU_DATA_W-1:0] b);
		logic [4:0]  sh;
		logic [63:0] ext;
		logic        lt_signed;
		sh = b[4:0];
		ext = {{32{a[31]}}, a} >> sh;
		// differing signs decide at once, otherwise magnitude order
		lt_signed = (a[31] != b[31]) ? a[31] : (a < b);
		case (op)
			alu_add:  return a + b;
			alu_sub:  return a + ~b + 32'd1;
			alu_sltu: return (a < b) ? 32'd1 : 32'd0;
			alu_slts: return lt_signed ? 32'd1 : 32'd0;
			alu_and:  return a & b;
			alu_orr:  return a | b;
			alu_xor:  return a ^ b;
			alu_lsl:  return a << sh;
			alu_lsr:  return a >> sh;
			alu_asr:  return ext[31:0];
			default:  return '0;
		endcase
	endfunction

	// groups 0, 2 and 3
	function automatic logic [`CPU_DATA_W-1:0] three_reg_word(input logic [3:0] grp,
		input logic [3:0] op, input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rc);
		return {grp, ra, rb, rc, 12'h000, op};
	endfunction

	// group 1
	function automatic logic [`CPU_DATA_W-1:0] reg_imm_word(input logic [3:0] op,
		input logic [3:0] ra, input logic [3:0] rb, input logic [15:0] imm);
		return {4'h1, op, ra, rb, imm};
	endfunction

	task automatic check_word(input string name, input int idx,
		input logic [`CPU_DATA_W-1:0] exp_addr, input logic [`CPU_DATA_W-1:0] exp_data,
		input logic [`CPU_DATA_W-1:0] act_addr, input logic [`CPU_DATA_W-1:0] act_data);
		num_checks++;
		if (act_addr !== exp_addr)
		begin
			err_count++;
			$display("FAILED %s: store %0d address expected %h actual %h",
				name, idx, exp_addr, act_addr);
		end
		num_checks++;
		if (act_data !== exp_data)
		begin
			err_count++;
			$display("FAILED %s: store %0d data expected %h actual %h",
				name, idx, exp_data, act_data);
		end
	endtask

	task automatic check_count(input string name, input int exp_cnt, input int act_cnt);
		num_checks++;
		if (act_cnt != exp_cnt)
		begin
			err_count++;
			$display("FAILED %s: store count expected %0d actual %0d", name, exp_cnt, act_cnt);
		end
	endtask

	// filler words decode as group 4 no-ops tagged with their address
	task automatic fill_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			prog_mem[i] = NOP_WORD | 32'(i);
	endtask

	// reset goes low here and stays low while the program is built
	task automatic start_program();
		@(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk);
		fill_memory();
		wp = 0;
		wr_addr_q.delete();
		wr_data_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic emit(input logic [`CPU_DATA_W-1:0] word);
		prog_mem[wp] = word;
		wp++;
	endtask

	task automatic pad_nops(input int n);
		for (int i = 0; i < n; i++)
			emit(NOP_WORD);
	endtask

	// cpyhi then orri on a register still cleared by reset
	task automatic load_reg(input logic [3:0] r, input logic [`CPU_DATA_W-1:0] value);
		emit(reg_imm_word(g1_cpyhi, r, 4'd0, value[31:16]));
		pad_nops(2);
		emit(reg_imm_word(g1_orri, r, r, value[15:0]));
		pad_nops(2);
	endtask

	task automatic store_reg(input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rc);
		emit(three_reg_word(grp_mem, g3_st32, ra, rb, rc));
	endtask

	// beq r0, r0 back onto itself
	task automatic end_with_self_loop();
		emit(reg_imm_word(g1_beq, 4'd0, 4'd0, 16'hfffc));
	endtask

	task automatic expect_write(input logic [`CPU_DATA_W-1:0] addr,
		input logic [`CPU_DATA_W-1:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic run_and_compare(input string name);
		int idle;
		int cycles;
		int seen;
		int n;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		idle = 0;
		cycles = 0;
		seen = 0;
		while ((wr_addr_q.size() < exp_addr_q.size()) && (idle < IDLE_LIMIT) &&
			(cycles < TEST_BUDGET))
		begin
			@(posedge clk);
			cycles++;
			if (wr_addr_q.size() != seen)
			begin
				seen = wr_addr_q.size();
				idle = 0;
			end
			else
				idle++;
		end
		// a stray extra store would show up in these cycles
		repeat (10) @(posedge clk);
		if (idle >= IDLE_LIMIT)
			$display("%s: no store seen for %0d cycles, stopped waiting", name, IDLE_LIMIT);
		check_count(name, exp_addr_q.size(), wr_addr_q.size());
		n = (exp_addr_q.size() < wr_addr_q.size()) ? exp_addr_q.size() : wr_addr_q.size();
		for (int i = 0; i < n; i++)
			check_word(name, i, exp_addr_q[i], exp_data_q[i], wr_addr_q[i], wr_data_q[i]);
	endtask

	// every alu operation on random rB and rC with each result stored at rB + rC
	task automatic reg_reg_alu();
		logic [`CPU_DATA_W-1:0] b_val;
		logic [`CPU_DATA_W-1:0] c_val;
		start_program();
		b_val = random_bits(32);
		c_val = random_bits(32);
		load_reg(4'd1, b_val);
		load_reg(4'd2, c_val);
		for (int op = 0; op <= 9; op++)
		begin
			emit(three_reg_word(grp_alu, 4'(op), 4'd3, 4'd1, 4'd2));
			pad_nops(2);
			store_reg(4'd3, 4'd1, 4'd2);
			expect_write(b_val + c_val, reference_alu(alu_op_e'(4'(op)), b_val, c_val));
		end
		end_with_self_loop();
		run_and_compare("reg_reg_alu");
	endtask

	task automatic immediate_ops();
		logic [`CPU_DATA_W-1:0] a_val;
		logic [`CPU_DATA_W-1:0] raw;
		logic [15:0]            imm;
		start_program();
		a_val = random_bits(32);
		load_reg(4'd1, a_val);
		emit(reg_imm_word(g1_addi, 4'd4, 4'd0, 16'h0800));
		pad_nops(2);
		// zero-extended group without sltsi
		for (int op = 0; op <= 9; op++)
		begin
			if (op != 3)
			begin
				raw = random_bits(16);
				imm = raw[15:0];
				emit(reg_imm_word(4'(op), 4'd3, 4'd1, imm));
				pad_nops(2);
				store_reg(4'd3, 4'd4, 4'd0);
				expect_write(32'h0800, reference_alu(alu_op_e'(4'(op)), a_val, {16'h0, imm}));
			end
		end
		// sign-extended compare against a negative immediate
		raw = random_bits(15);
		imm = 16'h8000 | raw[15:0];
		emit(reg_imm_word(g1_sltsi, 4'd3, 4'd1, imm));
		pad_nops(2);
		store_reg(4'd3, 4'd4, 4'd0);
		expect_write(32'h0800, reference_alu(alu_slts, a_val, {{16{imm[15]}}, imm}));
		raw = random_bits(16);
		imm = raw[15:0];
		emit(reg_imm_word(g1_cpyhi, 4'd1, 4'd0, imm));
		pad_nops(2);
		store_reg(4'd1, 4'd4, 4'd0);
		expect_write(32'h0800, {imm, a_val[15:0]});
		end_with_self_loop();
		run_and_compare("immediate_ops");
	endtask

	// r1 = 5, r2 = 7 and r3 = 5 with the path markers in r10 and r11
	task automatic control_setup();
		emit(reg_imm_word(g1_addi, 4'd1, 4'd0, 16'd5));
		emit(reg_imm_word(g1_addi, 4'd2, 4'd0, 16'd7));
		emit(reg_imm_word(g1_addi, 4'd3, 4'd0, 16'd5));
		emit(reg_imm_word(g1_addi, 4'd10, 4'd0, 16'h00a1));
		emit(reg_imm_word(g1_addi, 4'd11, 4'd0, 16'h00b2));
		pad_nops(2);
	endtask

	// taken path skips the a1 store and lands on the b2 store
	task automatic control_case(input logic is_jump, input logic is_ne,
		input logic [3:0] ra, input logic [3:0] rb,
		input logic [`CPU_DATA_W-1:0] va, input logic [`CPU_DATA_W-1:0] vb,
		input logic [15:0] base);
		logic [`CPU_DATA_W-1:0] ctrl_addr;
		logic                   taken;
		ctrl_addr = 32'((wp + 4) * `CPU_INSTR_BYTES);
		taken = is_ne ? (va != vb) : (va == vb);
		emit(reg_imm_word(g1_addi, 4'd13, 4'd0, base));
		emit(reg_imm_word(g1_addi, 4'd14, 4'd0, 16'(ctrl_addr + 32'd8)));
		pad_nops(2);
		if (is_jump)
			emit(three_reg_word(grp_jump, is_ne ? g2_jne : g2_jeq, ra, rb, 4'd14));
		else
			emit(reg_imm_word(is_ne ? g1_bne : g1_beq, ra, rb, 16'd4));
		store_reg(4'd10, 4'd13, 4'd0);
		store_reg(4'd11, 4'd13, 4'd0);
		if (!taken)
			expect_write({16'h0, base}, 32'h0000_00a1);
		expect_write({16'h0, base}, 32'h0000_00b2);
	endtask

	task automatic relative_branches();
		start_program();
		control_setup();
		control_case(1'b0, 1'b1, 4'd1, 4'd2, 32'd5, 32'd7, 16'h0900);
		control_case(1'b0, 1'b1, 4'd1, 4'd3, 32'd5, 32'd5, 16'h0910);
		control_case(1'b0, 1'b0, 4'd1, 4'd3, 32'd5, 32'd5, 16'h0920);
		control_case(1'b0, 1'b0, 4'd1, 4'd2, 32'd5, 32'd7, 16'h0930);
		end_with_self_loop();
		run_and_compare("relative_branches");
	endtask

	task automatic register_jumps();
		start_program();
		control_setup();
		control_case(1'b1, 1'b1, 4'd1, 4'd2, 32'd5, 32'd7, 16'h0a00);
		control_case(1'b1, 1'b1, 4'd1, 4'd3, 32'd5, 32'd5, 16'h0a10);
		control_case(1'b1, 1'b0, 4'd1, 4'd3, 32'd5, 32'd5, 16'h0a20);
		control_case(1'b1, 1'b0, 4'd1, 4'd2, 32'd5, 32'd7, 16'h0a30);
		end_with_self_loop();
		run_and_compare("register_jumps");
	endtask

	task automatic pc_relative_addsi();
		logic [`CPU_DATA_W-1:0] here;
		start_program();
		emit(reg_imm_word(g1_addi, 4'd4, 4'd0, 16'h0c00));
		pad_nops(2);
		// backwards offset of 32 bytes
		here = 32'(wp * `CPU_INSTR_BYTES);
		emit(reg_imm_word(g1_addsi, 4'd3, 4'd0, 16'hffe0));
		pad_nops(2);
		store_reg(4'd3, 4'd4, 4'd0);
		expect_write(32'h0c00, here - 32'd32);
		here = 32'(wp * `CPU_INSTR_BYTES);
		emit(reg_imm_word(g1_addsi, 4'd3, 4'd0, 16'h0124));
		pad_nops(2);
		store_reg(4'd3, 4'd4, 4'd0);
		expect_write(32'h0c00, here + 32'h0124);
		end_with_self_loop();
		run_and_compare("pc_relative_addsi");
	endtask

	task automatic silent_writes();
		logic [`CPU_DATA_W-1:0] keep_val;
		start_program();
		keep_val = random_bits(32);
		load_reg(4'd5, keep_val);
		emit(reg_imm_word(g1_addi, 4'd4, 4'd0, 16'h0d00));
		// both aim at r0
		emit(reg_imm_word(g1_addi, 4'd0, 4'd5, 16'h0123));
		emit(three_reg_word(grp_alu, g0_add, 4'd0, 4'd5, 4'd5));
		pad_nops(2);
		store_reg(4'd0, 4'd4, 4'd0);
		expect_write(32'h0d00, 32'h0);
		// bad opcodes and groups with r5 as rA
		emit(three_reg_word(grp_alu, 4'd12, 4'd5, 4'd5, 4'd5));
		emit(three_reg_word(grp_alu, 4'd15, 4'd5, 4'd0, 4'd0));
		emit(reg_imm_word(4'd14, 4'd5, 4'd5, 16'h7777));
		emit(reg_imm_word(4'd15, 4'd5, 4'd0, 16'h1234));
		emit(three_reg_word(4'd7, 4'd0, 4'd5, 4'd5, 4'd5));
		// these two stall but must fall through without a store
		emit(three_reg_word(grp_jump, 4'd5, 4'd5, 4'd5, 4'd5));
		emit(three_reg_word(grp_mem, 4'd3, 4'd5, 4'd0, 4'd0));
		pad_nops(2);
		store_reg(4'd5, 4'd4, 4'd0);
		expect_write(32'h0d00, keep_val);
		end_with_self_loop();
		run_and_compare("silent_writes");
	endtask

	initial
	begin
		rst_n = 1'b0;
		lfsr_state = 32'hc342;
		err_count = 0;
		num_checks = 0;
		wp = 0;
		fill_memory();
		reg_reg_alu();
		immediate_ops();
		relative_branches();
		register_jumps();
		pc_relative_addsi();
		silent_writes();
		$display("checks: %0d  errors: %0d", num_checks, err_count);
		if (err_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// bound on the whole run from the per test budgets
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run went past its cycle budget");
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
cpu_pkg.sv
instr_decoder.sv
register_file.sv
alu.sv
decode_stage.sv
execute_stage.sv
write_back_stage.sv
cpu_top.sv
tb_cpu_top.sv

/* Makefile */
SRCS := $(shell grep -v '^+' all.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_cpu_top: all.f $(SRCS) cpu_cfg.svh
	verilator --binary --timing --top-module tb_cpu_top -f all.f

run: obj_dir/Vtb_cpu_top
	@out="$$(./obj_dir/Vtb_cpu_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf obj_dir
